/* hw/lzss_pkg.sv */
`default_nettype none

package lzss_pkg;

    // byte and block limits
    localparam int BYTE_W          = 8;
    localparam int MAX_BLOCK       = 256;

    // match length limits
    localparam int MIN_MATCH       = 3;
    localparam int MAX_MATCH_LIMIT = 15;

    // a data byte
    typedef logic [BYTE_W-1:0] byte_t;

    // position inside a block, 0 to MAX_BLOCK-1
    typedef logic [$clog2(MAX_BLOCK)-1:0] pos_t;

    // byte count inside a block, 0 to MAX_BLOCK
    typedef logic [$clog2(MAX_BLOCK+1)-1:0] count_t;

    // match length, up to MAX_MATCH_LIMIT
    typedef logic [$clog2(MAX_MATCH_LIMIT+1)-1:0] len_t;

    // match distance back from the current position, 1 to MAX_BLOCK-1
    typedef logic [$clog2(MAX_BLOCK)-1:0] dist_t;

    // block controller states
    typedef enum logic [1:0] {
        FILL,
        REQUEST,
        WAIT,
        EMIT
    } parse_state_t;

endpackage

`default_nettype wire

/* hw/lzss_search_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface lzss_search_if;

    // request, held by the parser for the whole search
    logic               start;
    lzss_pkg::pos_t     pos;
    lzss_pkg::count_t   avail;

    // result, valid only in the cycle where done is high
    logic               done;
    logic               found;
    lzss_pkg::len_t     length;
    lzss_pkg::dist_t    distance;

    modport parser (
        output start,
        output pos,
        output avail,
        input  done,
        input  found,
        input  length,
        input  distance
    );

    modport searcher (
        input  start,
        input  pos,
        input  avail,
        output done,
        output found,
        output length,
        output distance
    );

endinterface

`default_nettype wire

/* hw/lzss_byte_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module lzss_byte_buffer #(
    parameter int BLOCK_BYTES = 64
) (
    input  wire                     reset,

    // write port from the input stream
    input  wire                     i_wr_en,
    input  wire lzss_pkg::pos_t     i_wr_addr,
    input  wire lzss_pkg::byte_t    i_wr_data,

    // searcher reads, history and future side
    input  wire lzss_pkg::pos_t     i_hist_addr,
    output lzss_pkg::byte_t         o_hist_data,
    input  wire lzss_pkg::pos_t     i_fut_addr,
    output lzss_pkg::byte_t         o_fut_data,

    // parser literal read
    input  wire lzss_pkg::pos_t     i_lit_addr,
    output lzss_pkg::byte_t         o_lit_data
);

    // address bits actually needed for the configured block size
    localparam int AW = (BLOCK_BYTES > 1) ? $clog2(BLOCK_BYTES) : 1;

    lzss_pkg::byte_t mem [BLOCK_BYTES];

    always_ff @(posedge reset) begin
        if (i_wr_en) begin
            mem[i_wr_addr[AW-1:0]] <= i_wr_data;
        end
    end

    // three independent combinational read ports
    assign o_hist_data = mem[i_hist_addr[AW-1:0]];
    assign o_fut_data  = mem[i_fut_addr[AW-1:0]];
    assign o_lit_data  = mem[i_lit_addr[AW-1:0]];

endmodule

`default_nettype wire

/* hw/lzss_match_search.sv */
`timescale 1ns/10ps
`default_nettype none

module lzss_match_search #(
    parameter int MAX_MATCH = 10
) (
    input  wire                     reset,
    input  wire                     lagger_ram_reset_A,

    lzss_search_if.searcher         search,

    // byte pair under comparison
    output lzss_pkg::pos_t          o_hist_addr,
    input  wire lzss_pkg::byte_t    i_hist_data,
    output lzss_pkg::pos_t          o_fut_addr,
    input  wire lzss_pkg::byte_t    i_fut_data
);

    typedef enum logic [1:0] {
        IDLE,
        NEXT_LEN,
        COMPARE
    } search_state_t;

    search_state_t      state;

    // loop counters
    lzss_pkg::len_t     cur_len;
    lzss_pkg::pos_t     cur_start;
    lzss_pkg::len_t     k;
    lzss_pkg::pos_t     pos_q;

    // first length to try for a new request
    lzss_pkg::len_t     first_len;
    logic               last_byte;

    // result registers
    logic               done_q;
    logic               found_q;
    lzss_pkg::len_t     length_q;
    lzss_pkg::dist_t    distance_q;

    // longest allowed length, clipped to the bytes left in the block
    always_comb begin
        if (search.avail > lzss_pkg::count_t'(MAX_MATCH)) begin
            first_len = lzss_pkg::len_t'(MAX_MATCH);
        end else begin
            first_len = lzss_pkg::len_t'(search.avail);
        end
    end

    assign last_byte   = (k == cur_len - lzss_pkg::len_t'(1));

    // start+k on the history side, pos+k on the future side
    assign o_hist_addr = cur_start + lzss_pkg::pos_t'(k);
    assign o_fut_addr  = pos_q + lzss_pkg::pos_t'(k);

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (search.start) begin
                        pos_q   <= search.pos;
                        cur_len <= first_len;
                        state   <= NEXT_LEN;
                    end
                end

                NEXT_LEN: begin
                    if (cur_len < lzss_pkg::len_t'(lzss_pkg::MIN_MATCH)) begin
                        // every length tried, nothing found
                        found_q <= 1'b0;
                        done_q  <= 1'b1;
                        state   <= IDLE;
                    end else if (lzss_pkg::pos_t'(cur_len) > pos_q) begin
                        // not enough history for this length
                        cur_len <= cur_len - lzss_pkg::len_t'(1);
                    end else begin
                        // nearest start whose chunk ends at pos
                        cur_start <= pos_q - lzss_pkg::pos_t'(cur_len);
                        k         <= '0;
                        state     <= COMPARE;
                    end
                end

                COMPARE: begin
                    if (i_hist_data != i_fut_data) begin
                        k <= '0;
                        if (cur_start == '0) begin
                            cur_len <= cur_len - lzss_pkg::len_t'(1);
                            state   <= NEXT_LEN;
                        end else begin
                            cur_start <= cur_start - lzss_pkg::pos_t'(1);
                        end
                    end else if (last_byte) begin
                        // whole chunk matched, first hit wins
                        found_q    <= 1'b1;
                        length_q   <= cur_len;
                        distance_q <= pos_q - cur_start;
                        done_q     <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        k <= k + lzss_pkg::len_t'(1);
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign search.done     = done_q;
    assign search.found    = found_q;
    assign search.length   = length_q;
    assign search.distance = distance_q;

endmodule

`default_nettype wire

/* hw/lzss_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module lzss_parser #(
    parameter int BLOCK_BYTES = 64
) (
    input  wire                     reset,
    input  wire                     lagger_ram_reset_A,

    // input byte stream
    input  wire                     i_in_valid,
    input  wire lzss_pkg::byte_t    i_in_data,
    input  wire                     i_in_last,
    output logic                    o_in_ready,

    // token stream
    output logic                    o_tok_valid,
    input  wire                     i_tok_ready,
    output logic                    o_tok_is_match,
    output lzss_pkg::byte_t         o_tok_literal,
    output lzss_pkg::len_t          o_tok_length,
    output lzss_pkg::dist_t         o_tok_distance,
    output logic                    o_tok_last,

    // buffer ports
    output logic                    o_wr_en,
    output lzss_pkg::pos_t          o_wr_addr,
    output lzss_pkg::byte_t         o_wr_data,
    output lzss_pkg::pos_t          o_lit_addr,
    input  wire lzss_pkg::byte_t    i_lit_data,

    lzss_search_if.parser           search
);

    lzss_pkg::parse_state_t state;
    lzss_pkg::count_t       blk_len;
    lzss_pkg::count_t       fill_next;
    lzss_pkg::pos_t         pos;
    lzss_pkg::pos_t         next_pos;
    lzss_pkg::count_t       step;
    lzss_pkg::count_t       pos_after;

    assign o_in_ready  = (state == lzss_pkg::FILL);
    assign o_tok_valid = (state == lzss_pkg::EMIT);

    // incoming bytes go straight into the buffer
    assign o_wr_en   = i_in_valid && o_in_ready;
    assign o_wr_addr = lzss_pkg::pos_t'(blk_len);
    assign o_wr_data = i_in_data;
    assign fill_next = blk_len + lzss_pkg::count_t'(1);

    assign o_lit_addr = pos;

    // search request for the current position
    assign search.start = (state == lzss_pkg::REQUEST);
    assign search.pos   = pos;
    assign search.avail = blk_len - lzss_pkg::count_t'(pos);

    // a match moves by its length, a literal by one byte
    assign step      = search.found ? lzss_pkg::count_t'(search.length) : lzss_pkg::count_t'(1);
    assign pos_after = lzss_pkg::count_t'(pos) + step;

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            state   <= lzss_pkg::FILL;
            blk_len <= '0;
            pos     <= '0;
        end else begin
            case (state)
                lzss_pkg::FILL: begin
                    if (o_wr_en) begin
                        blk_len <= fill_next;
                        // block closes on last or when the buffer is full
                        if (i_in_last || fill_next == lzss_pkg::count_t'(BLOCK_BYTES)) begin
                            pos   <= '0;
                            state <= lzss_pkg::REQUEST;
                        end
                    end
                end

                lzss_pkg::REQUEST: begin
                    state <= lzss_pkg::WAIT;
                end

                lzss_pkg::WAIT: begin
                    if (search.done) begin
                        state <= lzss_pkg::EMIT;
                    end
                end

                lzss_pkg::EMIT: begin
                    if (i_tok_ready) begin
                        pos <= next_pos;
                        if (o_tok_last) begin
                            blk_len <= '0;
                            state   <= lzss_pkg::FILL;
                        end else begin
                            state <= lzss_pkg::REQUEST;
                        end
                    end
                end

                default: begin
                    state <= lzss_pkg::FILL;
                end
            endcase
        end
    end

    // token payload, captured once per search result
    always_ff @(posedge reset) begin
        if (state == lzss_pkg::WAIT && search.done) begin
            o_tok_is_match <= search.found;
            o_tok_literal  <= i_lit_data;
            o_tok_length   <= search.length;
            o_tok_distance <= search.distance;
            o_tok_last     <= (pos_after == blk_len);
            next_pos       <= lzss_pkg::pos_t'(pos_after);
        end
    end

endmodule

`default_nettype wire

/* hw/lzss_compressor.sv */
`timescale 1ns/10ps
`default_nettype none

module lzss_compressor #(
    parameter int BLOCK_BYTES = 64,
    parameter int MAX_MATCH   = 10
) (
    input  wire                     reset,
    input  wire                     lagger_ram_reset_A,

    input  wire                     i_in_valid,
    input  wire lzss_pkg::byte_t    i_in_data,
    input  wire                     i_in_last,
    output logic                    o_in_ready,

    output logic                    o_tok_valid,
    input  wire                     i_tok_ready,
    output logic                    o_tok_is_match,
    output lzss_pkg::byte_t         o_tok_literal,
    output lzss_pkg::len_t          o_tok_length,
    output lzss_pkg::dist_t         o_tok_distance,
    output logic                    o_tok_last
);

    logic               wr_en;
    lzss_pkg::pos_t     wr_addr;
    lzss_pkg::byte_t    wr_data;
    lzss_pkg::pos_t     hist_addr;
    lzss_pkg::byte_t    hist_data;
    lzss_pkg::pos_t     fut_addr;
    lzss_pkg::byte_t    fut_data;
    lzss_pkg::pos_t     lit_addr;
    lzss_pkg::byte_t    lit_data;

    // request and result between the parser and the searcher
    lzss_search_if search_bus ();

    lzss_byte_buffer #(
        .BLOCK_BYTES (BLOCK_BYTES)
    ) i_lzss_byte_buffer (
        .reset       (reset),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_hist_addr (hist_addr),
        .o_hist_data (hist_data),
        .i_fut_addr  (fut_addr),
        .o_fut_data  (fut_data),
        .i_lit_addr  (lit_addr),
        .o_lit_data  (lit_data)
    );

    lzss_parser #(
        .BLOCK_BYTES (BLOCK_BYTES)
    ) i_lzss_parser (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .i_in_valid         (i_in_valid),
        .i_in_data          (i_in_data),
        .i_in_last          (i_in_last),
        .o_in_ready         (o_in_ready),
        .o_tok_valid        (o_tok_valid),
        .i_tok_ready        (i_tok_ready),
        .o_tok_is_match     (o_tok_is_match),
        .o_tok_literal      (o_tok_literal),
        .o_tok_length       (o_tok_length),
        .o_tok_distance     (o_tok_distance),
        .o_tok_last         (o_tok_last),
        .o_wr_en            (wr_en),
        .o_wr_addr          (wr_addr),
        .o_wr_data          (wr_data),
        .o_lit_addr         (lit_addr),
        .i_lit_data         (lit_data),
        .search             (search_bus.parser)
    );

    lzss_match_search #(
        .MAX_MATCH (MAX_MATCH)
    ) i_lzss_match_search (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .search             (search_bus.searcher),
        .o_hist_addr        (hist_addr),
        .i_hist_data        (hist_data),
        .o_fut_addr         (fut_addr),
        .i_fut_data         (fut_data)
    );

endmodule

`default_nettype wire

/* include/lzss_ref_model.svh */
`ifndef LZSS_REF_MODEL_SVH
`define LZSS_REF_MODEL_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// greedy parse of one block, one queue entry per token
function automatic void ref_parse(
    input  lzss_pkg::byte_t blk[$],
    input  int              max_match,
    output bit              exp_match[$],
    output lzss_pkg::byte_t exp_lit[$],
    output lzss_pkg::len_t  exp_len[$],
    output lzss_pkg::dist_t exp_dist[$]
);
    int pos;
    int len;
    int st;
    int k;
    bit hit;
    exp_match = {};
    exp_lit   = {};
    exp_len   = {};
    exp_dist  = {};
    pos = 0;
    while (pos < blk.size()) begin
        hit = 0;
        len = (blk.size() - pos < max_match) ? blk.size() - pos : max_match;
        // longest first, then nearest start first
        while (!hit && len >= lzss_pkg::MIN_MATCH) begin
            st = pos - len;
            while (!hit && st >= 0) begin
                hit = 1;
                for (k = 0; k < len; k++) begin
                    if (blk[st+k] != blk[pos+k]) begin
                        hit = 0;
                    end
                end
                if (!hit) begin
                    st--;
                end
            end
            if (!hit) begin
                len--;
            end
        end
        exp_match.push_back(hit);
        exp_lit.push_back(hit ? lzss_pkg::byte_t'(0) : blk[pos]);
        exp_len.push_back(hit ? lzss_pkg::len_t'(len) : lzss_pkg::len_t'(0));
        exp_dist.push_back(hit ? lzss_pkg::dist_t'(pos - st) : lzss_pkg::dist_t'(0));
        pos += hit ? len : 1;
    end
endfunction

// rebuild the block bytes from a token list
function automatic void ref_decode(
    input  bit              tok_match[$],
    input  lzss_pkg::byte_t tok_lit[$],
    input  lzss_pkg::len_t  tok_len[$],
    input  lzss_pkg::dist_t tok_dist[$],
    output lzss_pkg::byte_t out[$]
);
    int base;
    int k;
    out = {};
    foreach (tok_match[i]) begin
        if (tok_match[i]) begin
            base = out.size() - int'(tok_dist[i]);
            for (k = 0; k < int'(tok_len[i]); k++) begin
                out.push_back(out[base+k]);
            end
        end else begin
            out.push_back(tok_lit[i]);
        end
    end
endfunction

`endif

/* verification/lzss_compressor_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lzss_compressor_tb;

    localparam int BLOCK_BYTES = 64;
    localparam int MAX_MATCH   = 10;
    localparam int CLK_PERIOD  = 100;
    // total bytes sent over all tests
    localparam longint TEST_BYTES = 20 + 30 + 48 + 2 * BLOCK_BYTES + 2 * 32;
    localparam longint WATCHDOG_CYCLES = TEST_BYTES * BLOCK_BYTES * MAX_MATCH * MAX_MATCH + 1000;

    logic               reset;
    logic               lagger_ram_reset_A;
    logic               i_in_valid;
    lzss_pkg::byte_t    i_in_data;
    logic               i_in_last;
    logic               o_in_ready;
    logic               o_tok_valid;
    logic               i_tok_ready;
    logic               o_tok_is_match;
    lzss_pkg::byte_t    o_tok_literal;
    lzss_pkg::len_t     o_tok_length;
    lzss_pkg::dist_t    o_tok_distance;
    logic               o_tok_last;
    logic [31:0]        rng_state;

    // expected tokens from the model and received tokens from the DUT
    bit                 exp_match[$];
    lzss_pkg::byte_t    exp_lit[$];
    lzss_pkg::len_t     exp_len[$];
    lzss_pkg::dist_t    exp_dist[$];
    bit                 got_match[$];
    lzss_pkg::byte_t    got_lit[$];
    lzss_pkg::len_t     got_len[$];
    lzss_pkg::dist_t    got_dist[$];

`include "lzss_ref_model.svh"

    lzss_compressor #(
        .BLOCK_BYTES (BLOCK_BYTES),
        .MAX_MATCH   (MAX_MATCH)
    ) i_lzss_compressor (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .i_in_valid         (i_in_valid),
        .i_in_data          (i_in_data),
        .i_in_last          (i_in_last),
        .o_in_ready         (o_in_ready),
        .o_tok_valid        (o_tok_valid),
        .i_tok_ready        (i_tok_ready),
        .o_tok_is_match     (o_tok_is_match),
        .o_tok_literal      (o_tok_literal),
        .o_tok_length       (o_tok_length),
        .o_tok_distance     (o_tok_distance),
        .o_tok_last         (o_tok_last)
    );

    always #(CLK_PERIOD / 2) reset = ~reset;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_byte(input string name, input lzss_pkg::byte_t exp,
                              input lzss_pkg::byte_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected 0x%02h got 0x%02h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_length(input string name, input lzss_pkg::len_t exp,
                                input lzss_pkg::len_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_distance(input string name, input lzss_pkg::dist_t exp,
                                  input lzss_pkg::dist_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic send_block(input lzss_pkg::byte_t blk[$], input bit close_last);
        int idx;
        idx = 0;
        while (idx < blk.size()) begin
            i_in_valid <= 1'b1;
            i_in_data  <= blk[idx];
            i_in_last  <= close_last && (idx == blk.size() - 1);
            @(posedge reset);
            // ready as seen by the DUT on this edge
            if (o_in_ready) begin
                idx++;
            end
        end
        i_in_valid <= 1'b0;
        i_in_last  <= 1'b0;
    endtask

    task automatic collect_tokens(input bit random_ready);
        int          n;
        logic [31:0] r;
        n = 0;
        got_match = {};
        got_lit   = {};
        got_len   = {};
        got_dist  = {};
        while (n < exp_match.size()) begin
            r = next_random();
            i_tok_ready <= random_ready ? r[0] : 1'b1;
            @(posedge reset);
            if (o_in_ready) begin
                abort_run($sformatf("block ended after %0d of %0d tokens", n, exp_match.size()));
            end else if (o_tok_valid && i_tok_ready) begin
                check_flag("o_tok_is_match", exp_match[n], o_tok_is_match);
                if (exp_match[n]) begin
                    check_length("o_tok_length", exp_len[n], o_tok_length);
                    check_distance("o_tok_distance", exp_dist[n], o_tok_distance);
                end else begin
                    check_byte("o_tok_literal", exp_lit[n], o_tok_literal);
                end
                check_flag("o_tok_last", n == exp_match.size() - 1, o_tok_last);
                got_match.push_back(o_tok_is_match);
                got_lit.push_back(o_tok_is_match ? lzss_pkg::byte_t'(0) : o_tok_literal);
                got_len.push_back(o_tok_is_match ? o_tok_length : lzss_pkg::len_t'(0));
                got_dist.push_back(o_tok_is_match ? o_tok_distance : lzss_pkg::dist_t'(0));
                n++;
            end
        end
        i_tok_ready <= 1'b0;
        @(posedge reset);
        if (o_tok_valid) begin
            abort_run("DUT sent a token after the last token of the block");
        end
        check_flag("o_in_ready", 1'b1, o_in_ready);
    endtask

    // run one block through the DUT and check it against the model
    task automatic compress_block(input lzss_pkg::byte_t blk[$], input bit close_last,
                                  input bit random_ready);
        lzss_pkg::byte_t rebuilt[$];
        ref_parse(blk, MAX_MATCH, exp_match, exp_lit, exp_len, exp_dist);
        send_block(blk, close_last);
        @(posedge reset);
        check_flag("o_in_ready", 1'b0, o_in_ready);
        collect_tokens(random_ready);
        ref_decode(got_match, got_lit, got_len, got_dist, rebuilt);
        if (rebuilt.size() != blk.size()) begin
            abort_run("decoded token list has the wrong number of bytes");
        end
        foreach (blk[i]) begin
            check_byte("decoded byte", blk[i], rebuilt[i]);
        end
    endtask

    task automatic test_reset_state();
        @(posedge reset);
        check_flag("o_in_ready", 1'b1, o_in_ready);
        check_flag("o_tok_valid", 1'b0, o_tok_valid);
    endtask

    task automatic test_distinct_literals();
        lzss_pkg::byte_t blk[$];
        for (int i = 0; i < 20; i++) begin
            blk.push_back(lzss_pkg::byte_t'(i * 13 + 5));
        end
        compress_block(blk, 1'b1, 1'b0);
        if (got_match.size() != blk.size() || got_match.sum() with (int'(item)) != 0) begin
            abort_run("distinct bytes did not give one literal per byte");
        end
    endtask

    task automatic test_repetitive();
        lzss_pkg::byte_t blk[$];
        logic [31:0]     r;
        for (int i = 0; i < 30; i++) begin
            blk.push_back(lzss_pkg::byte_t'(8'h61 + i % 5));
        end
        compress_block(blk, 1'b1, 1'b0);
        blk = {};
        // 4-symbol alphabet
        for (int i = 0; i < 48; i++) begin
            r = next_random();
            blk.push_back(8'h41 + lzss_pkg::byte_t'(r[1:0]));
        end
        compress_block(blk, 1'b1, 1'b0);
    endtask

    task automatic test_full_block(input bit random_ready);
        lzss_pkg::byte_t blk[$];
        logic [31:0]     r;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            r = next_random();
            blk.push_back(8'h30 + lzss_pkg::byte_t'(r[2:0] & {1'b0, r[1:0] != 2'b11, 1'b1}));
        end
        // without last the block closes at BLOCK_BYTES
        compress_block(blk, 1'b0, random_ready);
    endtask

    task automatic test_back_to_back();
        lzss_pkg::byte_t blk[$];
        bit              prev_match[$];
        lzss_pkg::byte_t prev_lit[$];
        lzss_pkg::len_t  prev_len[$];
        lzss_pkg::dist_t prev_dist[$];
        for (int i = 0; i < 32; i++) begin
            blk.push_back(lzss_pkg::byte_t'(8'h70 + (i * 3) % 7));
        end
        compress_block(blk, 1'b1, 1'b0);
        prev_match = got_match;
        prev_lit   = got_lit;
        prev_len   = got_len;
        prev_dist  = got_dist;
        compress_block(blk, 1'b1, 1'b0);
        if (prev_match.size() != got_match.size()) begin
            abort_run("second identical block gave a different number of tokens");
        end
        foreach (prev_match[i]) begin
            check_flag("second block is_match", prev_match[i], got_match[i]);
            check_byte("second block literal", prev_lit[i], got_lit[i]);
            check_length("second block length", prev_len[i], got_len[i]);
            check_distance("second block distance", prev_dist[i], got_dist[i]);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired, the DUT stopped making progress");
    end

    initial begin
        reset              = 1'b0;
        lagger_ram_reset_A = 1'b1;
        i_in_valid         = 1'b0;
        i_in_data          = '0;
        i_in_last          = 1'b0;
        i_tok_ready        = 1'b0;
        rng_state          = 32'hc414;
        repeat (4) @(posedge reset);
        lagger_ram_reset_A <= 1'b0;
        test_reset_state();
        test_distinct_literals();
        test_repetitive();
        test_full_block(1'b0);
        test_full_block(1'b1);
        test_back_to_back();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/lzss_pkg.sv
hw/lzss_search_if.sv
hw/lzss_byte_buffer.sv
hw/lzss_match_search.sv
hw/lzss_parser.sv
hw/lzss_compressor.sv
verification/lzss_compressor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the LZSS compressor testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f project.f --top-module lzss_compressor_tb -o lzss_sim \
    && ./obj_dir/lzss_sim 2>&1 | tee sim.log \
    && grep -q "^TEST OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
